// ==== design/lce_cmd.sv ====
// ####################
// Command stage of the local cache engine
//   Fill and invalidate commands from the directory
//   Tag and data memory packets toward the cache
//   Directory response and fill completion
// ####################

`timescale 1ns/1ps

module lce_cmd (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic [lce_pkg::lce_id_width_p-1:0]    lce_id_i,

  input  logic                                  lce_cmd_v_i,
  input  lce_pkg::lce_cmd_op_e                  lce_cmd_op_i,
  input  logic [lce_pkg::addr_width_p-1:0]      lce_cmd_addr_i,
  input  logic [lce_pkg::way_width_p-1:0]       lce_cmd_way_i,
  input  lce_pkg::coh_state_e                   lce_cmd_state_i,
  input  logic [lce_pkg::block_width_p-1:0]     lce_cmd_data_i,
  output logic                                  lce_cmd_yumi_o,

  output logic                                  tag_mem_v_o,
  output logic [lce_pkg::set_width_p-1:0]       tag_mem_set_o,
  output logic [lce_pkg::way_width_p-1:0]       tag_mem_way_o,
  output logic [lce_pkg::tag_width_p-1:0]       tag_mem_tag_o,
  output lce_pkg::coh_state_e                   tag_mem_state_o,
  input  logic                                  tag_mem_yumi_i,

  output logic                                  data_mem_v_o,
  output logic [lce_pkg::set_width_p-1:0]       data_mem_set_o,
  output logic [lce_pkg::way_width_p-1:0]       data_mem_way_o,
  output logic [lce_pkg::block_width_p-1:0]     data_mem_data_o,
  input  logic                                  data_mem_yumi_i,

  output logic                                  lce_resp_v_o,
  output lce_pkg::lce_resp_type_e               lce_resp_type_o,
  output logic [lce_pkg::addr_width_p-1:0]      lce_resp_addr_o,
  output logic [lce_pkg::lce_id_width_p-1:0]    lce_resp_src_o,
  input  logic                                  lce_resp_ready_i,

  output logic                                  cache_req_complete_o
);

  localparam logic [1:0] st_idle_lp = 2'd0;
  localparam logic [1:0] st_mem_lp  = 2'd1;
  localparam logic [1:0] st_resp_lp = 2'd2;

  logic [1:0]                        state_r;
  logic                              tag_pend_r;
  logic                              data_pend_r;
  logic                              fill_r;
  logic [lce_pkg::addr_width_p-1:0]  addr_r;
  logic [lce_pkg::way_width_p-1:0]   way_r;
  lce_pkg::coh_state_e               tag_state_r;
  logic [lce_pkg::block_width_p-1:0] data_r;
  logic                              cmd_is_fill;
  logic                              tag_left;
  logic                              data_left;
  logic                              resp_fire;

  assign lce_cmd_yumi_o = (state_r == st_idle_lp) & lce_cmd_v_i;
  assign cmd_is_fill    = (lce_cmd_op_i == lce_pkg::e_cmd_fill);

  // Packets still owed after this cycle's yumis
  assign tag_left  = tag_pend_r & ~tag_mem_yumi_i;
  assign data_left = data_pend_r & ~data_mem_yumi_i;
  assign resp_fire = lce_resp_v_o & lce_resp_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r     <= st_idle_lp;
      tag_pend_r  <= 1'b0;
      data_pend_r <= 1'b0;
    end else begin
      case (state_r)
        st_idle_lp: begin
          if (lce_cmd_yumi_o) begin
            state_r     <= st_mem_lp;
            tag_pend_r  <= 1'b1;
            // Invalidate touches only the tag
            data_pend_r <= cmd_is_fill;
          end
        end
        st_mem_lp: begin
          tag_pend_r  <= tag_left;
          data_pend_r <= data_left;
          if (~tag_left & ~data_left) begin
            state_r <= st_resp_lp;
          end
        end
        st_resp_lp: begin
          if (resp_fire) begin
            state_r <= st_idle_lp;
          end
        end
        default: state_r <= st_idle_lp;
      endcase
    end
  end

  // Command payload
  always_ff @(posedge clk_i) begin
    if (lce_cmd_yumi_o) begin
      fill_r      <= cmd_is_fill;
      addr_r      <= lce_cmd_addr_i;
      way_r       <= lce_cmd_way_i;
      data_r      <= lce_cmd_data_i;
      tag_state_r <= cmd_is_fill ? lce_cmd_state_i : lce_pkg::e_coh_i;
    end
  end

  assign tag_mem_v_o     = tag_pend_r;
  assign tag_mem_set_o   = addr_r[lce_pkg::offset_width_p +: lce_pkg::set_width_p];
  assign tag_mem_way_o   = way_r;
  assign tag_mem_tag_o   = addr_r[lce_pkg::addr_width_p-1 -: lce_pkg::tag_width_p];
  assign tag_mem_state_o = tag_state_r;

  assign data_mem_v_o    = data_pend_r;
  assign data_mem_set_o  = addr_r[lce_pkg::offset_width_p +: lce_pkg::set_width_p];
  assign data_mem_way_o  = way_r;
  assign data_mem_data_o = data_r;

  assign lce_resp_v_o    = (state_r == st_resp_lp);
  assign lce_resp_type_o = fill_r ? lce_pkg::e_resp_coh_ack : lce_pkg::e_resp_inv_ack;
  assign lce_resp_addr_o = addr_r;
  assign lce_resp_src_o  = lce_id_i;

  // Fill done once its ack is taken
  assign cache_req_complete_o = resp_fire & (lce_resp_type_o == lce_pkg::e_resp_coh_ack);

endmodule

// ==== design/lce_pkg.sv ====
// ####################
// Shared definitions for the local cache engine
//   Address split and block widths
//   Miss, command and response encodings
//   Coherence state encoding
// ####################

package lce_pkg;

  // Address and block geometry
  localparam int addr_width_p   = 16;
  localparam int offset_width_p = 3;
  localparam int block_width_p  = 64;
  localparam int lce_id_width_p = 2;
  localparam int sets_p         = 16;
  localparam int assoc_p        = 2;

  // Derived widths, tag takes the bits above set and offset
  localparam int set_width_p = $clog2(sets_p);
  localparam int way_width_p = $clog2(assoc_p);
  localparam int tag_width_p = addr_width_p - set_width_p - offset_width_p;

  typedef enum logic [0:0] {
    e_req_rd = 1'b0,
    e_req_wr = 1'b1
  } lce_req_type_e;

  // Remaining opcodes are reserved
  typedef enum logic [1:0] {
    e_cmd_fill  = 2'b00,
    e_cmd_inval = 2'b01
  } lce_cmd_op_e;

  typedef enum logic [0:0] {
    e_resp_coh_ack = 1'b0,
    e_resp_inv_ack = 1'b1
  } lce_resp_type_e;

  typedef enum logic [1:0] {
    e_coh_i = 2'b00,
    e_coh_s = 2'b01,
    e_coh_m = 2'b11
  } coh_state_e;

endpackage

// ==== design/lce_req.sv ====
// ####################
// Request stage of the local cache engine
//   Takes cache misses and sends them to the directory
//   Credit counter for outstanding misses
// ####################

`timescale 1ns/1ps

module lce_req #(
  parameter int credits_p = 4
) (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic [lce_pkg::lce_id_width_p-1:0]    lce_id_i,

  input  logic                                  cache_req_v_i,
  input  lce_pkg::lce_req_type_e                cache_req_type_i,
  input  logic [lce_pkg::addr_width_p-1:0]      cache_req_addr_i,
  input  logic                                  cache_req_complete_i,
  output logic                                  ready_o,

  output logic                                  lce_req_v_o,
  input  logic                                  lce_req_ready_i,
  output lce_pkg::lce_req_type_e                lce_req_type_o,
  output logic [lce_pkg::addr_width_p-1:0]      lce_req_addr_o,
  output logic [lce_pkg::lce_id_width_p-1:0]    lce_req_src_o,

  output logic                                  credits_full_o,
  output logic                                  credits_empty_o
);

  localparam int cnt_width_lp = $clog2(credits_p + 1);
  localparam logic [cnt_width_lp-1:0] credits_max_lp = cnt_width_lp'(credits_p);

  localparam logic st_ready_lp = 1'b0;
  localparam logic st_send_lp  = 1'b1;

  logic                             state_r;
  logic [cnt_width_lp-1:0]          credit_cnt_r;
  lce_pkg::lce_req_type_e           type_r;
  logic [lce_pkg::addr_width_p-1:0] addr_r;
  logic                             req_fire;
  logic                             lce_fire;

  assign req_fire = cache_req_v_i & ready_o;
  assign lce_fire = lce_req_v_o & lce_req_ready_i;

  // Idle and a free credit
  assign ready_o = (state_r == st_ready_lp) & ~credits_full_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= st_ready_lp;
    end else begin
      case (state_r)
        st_ready_lp: begin
          if (req_fire) begin
            state_r <= st_send_lp;
          end
        end
        st_send_lp: begin
          if (lce_fire) begin
            state_r <= st_ready_lp;
          end
        end
        default: state_r <= st_ready_lp;
      endcase
    end
  end

  // Miss held until the directory takes it
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      type_r <= cache_req_type_i;
      addr_r <= cache_req_addr_i;
    end
  end

  // Up on a sent request, down on a completed fill
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credit_cnt_r <= '0;
    end else if (lce_fire & ~cache_req_complete_i) begin
      credit_cnt_r <= credit_cnt_r + cnt_width_lp'(1);
    end else if (~lce_fire & cache_req_complete_i) begin
      credit_cnt_r <= credit_cnt_r - cnt_width_lp'(1);
    end
  end

  assign credits_full_o  = (credit_cnt_r == credits_max_lp);
  assign credits_empty_o = (credit_cnt_r == '0);

  assign lce_req_v_o    = (state_r == st_send_lp);
  assign lce_req_type_o = type_r;
  assign lce_req_addr_o = addr_r;
  assign lce_req_src_o  = lce_id_i;

endmodule

// ==== design/lce_stall_timer.sv ====
// ####################
// Stall timer of the local cache engine
//   Counts cycles blocked on a memory port
//   Gates the cache ready
// ####################

`timescale 1ns/1ps

module lce_stall_timer #(
  parameter int timeout_max_p = 4
) (
  input  logic clk_i,
  input  logic reset_i,
  input  logic tag_mem_v_i,
  input  logic tag_mem_yumi_i,
  input  logic data_mem_v_i,
  input  logic data_mem_yumi_i,
  input  logic req_ready_i,
  output logic cache_req_ready_o
);

  localparam int cnt_width_lp = $clog2(timeout_max_p + 1);
  localparam logic [cnt_width_lp-1:0] cnt_max_lp = cnt_width_lp'(timeout_max_p);

  logic [cnt_width_lp-1:0] cnt_r;
  logic                    blocked;
  logic                    timeout;

  // Some packet waiting on the cache this cycle
  assign blocked = (tag_mem_v_i & ~tag_mem_yumi_i) | (data_mem_v_i & ~data_mem_yumi_i);
  assign timeout = (cnt_r == cnt_max_lp);

  // Saturates at the limit
  always_ff @(posedge clk_i) begin
    if (reset_i | ~blocked) begin
      cnt_r <= '0;
    end else if (~timeout) begin
      cnt_r <= cnt_r + cnt_width_lp'(1);
    end
  end

  // Withholding ready frees a memory cycle for the engine
  assign cache_req_ready_o = req_ready_i & ~timeout;

endmodule

// ==== design/lce_top.sv ====
// ####################
// Local cache engine top level
//   Request stage, command stage and stall timer
// ####################

`timescale 1ns/1ps

module lce_top #(
  parameter int credits_p     = 4,
  parameter int timeout_max_p = 4
) (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic [lce_pkg::lce_id_width_p-1:0]    lce_id_i,

  // Cache misses
  input  logic                                  cache_req_v_i,
  input  lce_pkg::lce_req_type_e                cache_req_type_i,
  input  logic [lce_pkg::addr_width_p-1:0]      cache_req_addr_i,
  output logic                                  cache_req_ready_o,
  output logic                                  cache_req_complete_o,
  output logic                                  credits_full_o,
  output logic                                  credits_empty_o,

  // Requests to the directory
  output logic                                  lce_req_v_o,
  output lce_pkg::lce_req_type_e                lce_req_type_o,
  output logic [lce_pkg::addr_width_p-1:0]      lce_req_addr_o,
  output logic [lce_pkg::lce_id_width_p-1:0]    lce_req_src_o,
  input  logic                                  lce_req_ready_i,

  // Commands from the directory
  input  logic                                  lce_cmd_v_i,
  input  lce_pkg::lce_cmd_op_e                  lce_cmd_op_i,
  input  logic [lce_pkg::addr_width_p-1:0]      lce_cmd_addr_i,
  input  logic [lce_pkg::way_width_p-1:0]       lce_cmd_way_i,
  input  lce_pkg::coh_state_e                   lce_cmd_state_i,
  input  logic [lce_pkg::block_width_p-1:0]     lce_cmd_data_i,
  output logic                                  lce_cmd_yumi_o,

  // Tag and data memory packets
  output logic                                  tag_mem_v_o,
  output logic [lce_pkg::set_width_p-1:0]       tag_mem_set_o,
  output logic [lce_pkg::way_width_p-1:0]       tag_mem_way_o,
  output logic [lce_pkg::tag_width_p-1:0]       tag_mem_tag_o,
  output lce_pkg::coh_state_e                   tag_mem_state_o,
  input  logic                                  tag_mem_yumi_i,
  output logic                                  data_mem_v_o,
  output logic [lce_pkg::set_width_p-1:0]       data_mem_set_o,
  output logic [lce_pkg::way_width_p-1:0]       data_mem_way_o,
  output logic [lce_pkg::block_width_p-1:0]     data_mem_data_o,
  input  logic                                  data_mem_yumi_i,

  // Responses to the directory
  output logic                                  lce_resp_v_o,
  output lce_pkg::lce_resp_type_e               lce_resp_type_o,
  output logic [lce_pkg::addr_width_p-1:0]      lce_resp_addr_o,
  output logic [lce_pkg::lce_id_width_p-1:0]    lce_resp_src_o,
  input  logic                                  lce_resp_ready_i
);

  logic req_ready_lo;

  // Miss counts only when the gated ready is seen by the cache
  lce_req #(
    .credits_p(credits_p)
  ) u_req (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .lce_id_i(lce_id_i),
    .cache_req_v_i(cache_req_v_i & cache_req_ready_o),
    .cache_req_type_i(cache_req_type_i),
    .cache_req_addr_i(cache_req_addr_i),
    .cache_req_complete_i(cache_req_complete_o),
    .ready_o(req_ready_lo),
    .lce_req_v_o(lce_req_v_o),
    .lce_req_ready_i(lce_req_ready_i),
    .lce_req_type_o(lce_req_type_o),
    .lce_req_addr_o(lce_req_addr_o),
    .lce_req_src_o(lce_req_src_o),
    .credits_full_o(credits_full_o),
    .credits_empty_o(credits_empty_o)
  );

  lce_cmd u_cmd (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .lce_id_i(lce_id_i),
    .lce_cmd_v_i(lce_cmd_v_i),
    .lce_cmd_op_i(lce_cmd_op_i),
    .lce_cmd_addr_i(lce_cmd_addr_i),
    .lce_cmd_way_i(lce_cmd_way_i),
    .lce_cmd_state_i(lce_cmd_state_i),
    .lce_cmd_data_i(lce_cmd_data_i),
    .lce_cmd_yumi_o(lce_cmd_yumi_o),
    .tag_mem_v_o(tag_mem_v_o),
    .tag_mem_set_o(tag_mem_set_o),
    .tag_mem_way_o(tag_mem_way_o),
    .tag_mem_tag_o(tag_mem_tag_o),
    .tag_mem_state_o(tag_mem_state_o),
    .tag_mem_yumi_i(tag_mem_yumi_i),
    .data_mem_v_o(data_mem_v_o),
    .data_mem_set_o(data_mem_set_o),
    .data_mem_way_o(data_mem_way_o),
    .data_mem_data_o(data_mem_data_o),
    .data_mem_yumi_i(data_mem_yumi_i),
    .lce_resp_v_o(lce_resp_v_o),
    .lce_resp_type_o(lce_resp_type_o),
    .lce_resp_addr_o(lce_resp_addr_o),
    .lce_resp_src_o(lce_resp_src_o),
    .lce_resp_ready_i(lce_resp_ready_i),
    .cache_req_complete_o(cache_req_complete_o)
  );

  lce_stall_timer #(
    .timeout_max_p(timeout_max_p)
  ) u_timer (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .tag_mem_v_i(tag_mem_v_o),
    .tag_mem_yumi_i(tag_mem_yumi_i),
    .data_mem_v_i(data_mem_v_o),
    .data_mem_yumi_i(data_mem_yumi_i),
    .req_ready_i(req_ready_lo),
    .cache_req_ready_o(cache_req_ready_o)
  );

endmodule

// ==== dv/lce_asserts.sv ====
// ####################
// Bound assertions for lce_top
//   Request and response stability
//   Credit flags and fill completion
// ####################

`timescale 1ns/1ps

module lce_asserts (
  input logic                                 clk_i,
  input logic                                 reset_i,
  input logic                                 lce_req_v_o,
  input logic                                 lce_req_ready_i,
  input lce_pkg::lce_req_type_e               lce_req_type_o,
  input logic [lce_pkg::addr_width_p-1:0]     lce_req_addr_o,
  input logic [lce_pkg::lce_id_width_p-1:0]   lce_req_src_o,
  input logic                                 lce_resp_v_o,
  input logic                                 lce_resp_ready_i,
  input lce_pkg::lce_resp_type_e              lce_resp_type_o,
  input logic [lce_pkg::addr_width_p-1:0]     lce_resp_addr_o,
  input logic [lce_pkg::lce_id_width_p-1:0]   lce_resp_src_o,
  input logic                                 credits_full_o,
  input logic                                 credits_empty_o,
  input logic                                 cache_req_complete_o
);

  // Held request keeps its fields
  req_stable_a: assert property (@(posedge clk_i) disable iff (reset_i)
    lce_req_v_o && !lce_req_ready_i |=> lce_req_v_o && $stable(lce_req_addr_o)
      && $stable(lce_req_type_o) && $stable(lce_req_src_o))
    else $error("LCE request changed while waiting for ready");

  resp_stable_a: assert property (@(posedge clk_i) disable iff (reset_i)
    lce_resp_v_o && !lce_resp_ready_i |=> lce_resp_v_o && $stable(lce_resp_addr_o)
      && $stable(lce_resp_type_o) && $stable(lce_resp_src_o))
    else $error("LCE response changed while waiting for ready");

  credits_a: assert property (@(posedge clk_i) disable iff (reset_i)
    !(credits_full_o && credits_empty_o))
    else $error("Credit counter reports full and empty together");

  complete_a: assert property (@(posedge clk_i) disable iff (reset_i)
    cache_req_complete_o |-> lce_resp_v_o && lce_resp_ready_i
      && lce_resp_type_o == lce_pkg::e_resp_coh_ack)
    else $error("Completion pulse without a fill ack handshake");

endmodule

bind lce_top lce_asserts u_asserts (
  .clk_i(clk_i),
  .reset_i(reset_i),
  .lce_req_v_o(lce_req_v_o),
  .lce_req_ready_i(lce_req_ready_i),
  .lce_req_type_o(lce_req_type_o),
  .lce_req_addr_o(lce_req_addr_o),
  .lce_req_src_o(lce_req_src_o),
  .lce_resp_v_o(lce_resp_v_o),
  .lce_resp_ready_i(lce_resp_ready_i),
  .lce_resp_type_o(lce_resp_type_o),
  .lce_resp_addr_o(lce_resp_addr_o),
  .lce_resp_src_o(lce_resp_src_o),
  .credits_full_o(credits_full_o),
  .credits_empty_o(credits_empty_o),
  .cache_req_complete_o(cache_req_complete_o)
);

// ==== dv/tb_lce.sv ====
// ####################
// Testbench for the local cache engine
//   Directory and memory models
//   Reference function and checker
//   Directed tests and a random run
// ####################

`timescale 1ns/1ps

module tb_lce;

  localparam int wait_limit_lp = 400;

  typedef struct packed {
    logic [lce_pkg::set_width_p-1:0]   set;
    logic [lce_pkg::tag_width_p-1:0]   tag;
    logic [lce_pkg::way_width_p-1:0]   way;
    lce_pkg::coh_state_e               state;
    logic                              has_data;
    logic [lce_pkg::block_width_p-1:0] data;
    lce_pkg::lce_resp_type_e           resp;
    logic [lce_pkg::addr_width_p-1:0]  addr;
  } expect_t;

  logic                              clk_i;
  logic                              reset_i;
  logic [lce_pkg::lce_id_width_p-1:0] lce_id_i;
  logic                              cache_req_v_i;
  lce_pkg::lce_req_type_e            cache_req_type_i;
  logic [lce_pkg::addr_width_p-1:0]  cache_req_addr_i;
  logic                              cache_req_ready_o;
  logic                              cache_req_complete_o;
  logic                              credits_full_o;
  logic                              credits_empty_o;
  logic                              lce_req_v_o;
  lce_pkg::lce_req_type_e            lce_req_type_o;
  logic [lce_pkg::addr_width_p-1:0]  lce_req_addr_o;
  logic [lce_pkg::lce_id_width_p-1:0] lce_req_src_o;
  logic                              lce_req_ready_i;
  logic                              lce_cmd_v_i;
  lce_pkg::lce_cmd_op_e              lce_cmd_op_i;
  logic [lce_pkg::addr_width_p-1:0]  lce_cmd_addr_i;
  logic [lce_pkg::way_width_p-1:0]   lce_cmd_way_i;
  lce_pkg::coh_state_e               lce_cmd_state_i;
  logic [lce_pkg::block_width_p-1:0] lce_cmd_data_i;
  logic                              lce_cmd_yumi_o;
  logic                              tag_mem_v_o;
  logic [lce_pkg::set_width_p-1:0]   tag_mem_set_o;
  logic [lce_pkg::way_width_p-1:0]   tag_mem_way_o;
  logic [lce_pkg::tag_width_p-1:0]   tag_mem_tag_o;
  lce_pkg::coh_state_e               tag_mem_state_o;
  logic                              tag_mem_yumi_i;
  logic                              data_mem_v_o;
  logic [lce_pkg::set_width_p-1:0]   data_mem_set_o;
  logic [lce_pkg::way_width_p-1:0]   data_mem_way_o;
  logic [lce_pkg::block_width_p-1:0] data_mem_data_o;
  logic                              data_mem_yumi_i;
  logic                              lce_resp_v_o;
  lce_pkg::lce_resp_type_e           lce_resp_type_o;
  logic [lce_pkg::addr_width_p-1:0]  lce_resp_addr_o;
  logic [lce_pkg::lce_id_width_p-1:0] lce_resp_src_o;
  logic                              lce_resp_ready_i;

  int   seed       = 32'h3b47;
  logic rand_bp    = 1'b0;
  int   dir_rd     = 0;
  int   open_cmds  = 0;
  expect_t exp_r   = '0;
  logic tag_done   = 1'b0;
  logic data_done  = 1'b0;
  lce_pkg::lce_req_type_e           miss_type_q[$];
  logic [lce_pkg::addr_width_p-1:0] miss_addr_q[$];
  // Requests taken by the directory model, in order
  logic [lce_pkg::addr_width_p-1:0] dir_q[$];

  always #50 clk_i = ~clk_i;

  lce_top #(
    .credits_p(4),
    .timeout_max_p(4)
  ) u_dut (.*);

  task automatic finish_fail();
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic timeout_fail(input string what);
    $display("Timed out waiting for %s", what);
    finish_fail();
  endtask

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
      finish_fail();
    end
  endtask

  function automatic logic [31:0] rnd();
    return $random(seed);
  endfunction

  // Expected packets and response for one directory command
  function automatic expect_t expect_of(input lce_pkg::lce_cmd_op_e op,
      input logic [lce_pkg::addr_width_p-1:0] addr,
      input logic [lce_pkg::way_width_p-1:0] way, input lce_pkg::coh_state_e st,
      input logic [lce_pkg::block_width_p-1:0] data);
    expect_t e;
    logic [lce_pkg::addr_width_p-1:0] above_offset;
    logic is_fill;
    is_fill      = (op == lce_pkg::e_cmd_fill);
    // Offset drops out, set index comes next, tag is the rest
    above_offset = addr >> lce_pkg::offset_width_p;
    e.set        = above_offset[lce_pkg::set_width_p-1:0];
    e.tag        = above_offset[lce_pkg::set_width_p +: lce_pkg::tag_width_p];
    e.way        = way;
    e.state      = is_fill ? st : lce_pkg::e_coh_i;
    e.has_data   = is_fill;
    e.data       = data;
    e.resp       = is_fill ? lce_pkg::e_resp_coh_ack : lce_pkg::e_resp_inv_ack;
    e.addr       = addr;
    return e;
  endfunction

  always @(posedge clk_i) begin : compare
    logic [lce_pkg::addr_width_p-1:0] a;
    lce_pkg::lce_req_type_e t;
    logic comp_exp;
    if (!reset_i) begin
      if (lce_req_v_o && lce_req_ready_i) begin
        assert (miss_addr_q.size() > 0) else begin
          $display("LCE request seen without an accepted cache miss");
          finish_fail();
        end
        t = miss_type_q.pop_front();
        a = miss_addr_q.pop_front();
        check_eq("lce_req_type_o", 64'(lce_req_type_o), 64'(t));
        check_eq("lce_req_addr_o", 64'(lce_req_addr_o), 64'(a));
        check_eq("lce_req_src_o", 64'(lce_req_src_o), 64'(lce_id_i));
        dir_q.push_back(a);
      end
      if (cache_req_v_i && cache_req_ready_o) begin
        miss_type_q.push_back(cache_req_type_i);
        miss_addr_q.push_back(cache_req_addr_i);
      end
      if (tag_mem_v_o && tag_mem_yumi_i) begin
        assert (!tag_done) else begin
          $display("Second tag packet for one command");
          finish_fail();
        end
        check_eq("tag_mem_set_o", 64'(tag_mem_set_o), 64'(exp_r.set));
        check_eq("tag_mem_way_o", 64'(tag_mem_way_o), 64'(exp_r.way));
        check_eq("tag_mem_tag_o", 64'(tag_mem_tag_o), 64'(exp_r.tag));
        check_eq("tag_mem_state_o", 64'(tag_mem_state_o), 64'(exp_r.state));
        tag_done = 1'b1;
      end
      if (data_mem_v_o && data_mem_yumi_i) begin
        assert (exp_r.has_data && !data_done) else begin
          $display("Unexpected data packet for this command");
          finish_fail();
        end
        check_eq("data_mem_set_o", 64'(data_mem_set_o), 64'(exp_r.set));
        check_eq("data_mem_way_o", 64'(data_mem_way_o), 64'(exp_r.way));
        check_eq("data_mem_data_o", data_mem_data_o, exp_r.data);
        data_done = 1'b1;
      end
      // Completion only with a fill ack handshake
      comp_exp = lce_resp_v_o && lce_resp_ready_i && exp_r.resp == lce_pkg::e_resp_coh_ack;
      check_eq("cache_req_complete_o", 64'(cache_req_complete_o), 64'(comp_exp));
      if (lce_resp_v_o && lce_resp_ready_i) begin
        assert (open_cmds == 1 && tag_done && data_done == exp_r.has_data) else begin
          $display("Response sent before its memory packets were taken");
          finish_fail();
        end
        check_eq("lce_resp_type_o", 64'(lce_resp_type_o), 64'(exp_r.resp));
        check_eq("lce_resp_addr_o", 64'(lce_resp_addr_o), 64'(exp_r.addr));
        check_eq("lce_resp_src_o", 64'(lce_resp_src_o), 64'(lce_id_i));
        open_cmds--;
      end
      if (lce_cmd_v_i && lce_cmd_yumi_o) begin
        exp_r = expect_of(lce_cmd_op_i, lce_cmd_addr_i, lce_cmd_way_i, lce_cmd_state_i,
                          lce_cmd_data_i);
        tag_done  = 1'b0;
        data_done = 1'b0;
        open_cmds++;
      end
    end
  end

  // Next falling edge, with random back-pressure in the random run
  task automatic step();
    logic [31:0] r;
    @(negedge clk_i);
    if (rand_bp) begin
      r = rnd();
      lce_req_ready_i  = r[0];
      tag_mem_yumi_i   = r[1];
      data_mem_yumi_i  = r[2];
      lce_resp_ready_i = r[3];
    end
  endtask

  task automatic send_miss(input lce_pkg::lce_req_type_e t,
      input logic [lce_pkg::addr_width_p-1:0] a);
    int n;
    step();
    cache_req_v_i    = 1'b1;
    cache_req_type_i = t;
    cache_req_addr_i = a;
    n = 0;
    @(posedge clk_i);
    while (!cache_req_ready_o) begin
      n++;
      if (n > wait_limit_lp) timeout_fail("cache_req_ready_o");
      step();
      @(posedge clk_i);
    end
    step();
    cache_req_v_i = 1'b0;
  endtask

  task automatic send_cmd(input lce_pkg::lce_cmd_op_e op,
      input logic [lce_pkg::addr_width_p-1:0] a, input logic [lce_pkg::way_width_p-1:0] way,
      input lce_pkg::coh_state_e st, input logic [lce_pkg::block_width_p-1:0] data);
    int n;
    step();
    lce_cmd_v_i     = 1'b1;
    lce_cmd_op_i    = op;
    lce_cmd_addr_i  = a;
    lce_cmd_way_i   = way;
    lce_cmd_state_i = st;
    lce_cmd_data_i  = data;
    n = 0;
    @(posedge clk_i);
    while (!lce_cmd_yumi_o) begin
      n++;
      if (n > wait_limit_lp) timeout_fail("lce_cmd_yumi_o");
      step();
      @(posedge clk_i);
    end
    step();
    lce_cmd_v_i = 1'b0;
  endtask

  // Directory answers each queued request with a fill
  task automatic serve_fills(input int count);
    logic [31:0] r;
    int n;
    for (int i = 0; i < count; i++) begin
      n = 0;
      while (dir_q.size() <= dir_rd) begin
        n++;
        if (n > wait_limit_lp) timeout_fail("a directory request");
        step();
      end
      r = rnd();
      send_cmd(lce_pkg::e_cmd_fill, dir_q[dir_rd], r[0],
               r[1] ? lce_pkg::e_coh_m : lce_pkg::e_coh_s, {rnd(), rnd()});
      dir_rd++;
    end
  endtask

  task automatic wait_quiet();
    int n;
    n = 0;
    while (open_cmds != 0 || miss_addr_q.size() != 0 || lce_req_v_o || tag_mem_v_o
           || data_mem_v_o || lce_resp_v_o) begin
      n++;
      if (n > wait_limit_lp) timeout_fail("the engine to drain");
      step();
    end
  endtask

  initial begin
    logic [31:0] r;
    int n;
    int k;
    clk_i            = 1'b0;
    reset_i          = 1'b1;
    lce_id_i         = 2'd2;
    cache_req_v_i    = 1'b0;
    cache_req_type_i = lce_pkg::e_req_rd;
    cache_req_addr_i = '0;
    lce_req_ready_i  = 1'b1;
    lce_cmd_v_i      = 1'b0;
    lce_cmd_op_i     = lce_pkg::e_cmd_fill;
    lce_cmd_addr_i   = '0;
    lce_cmd_way_i    = '0;
    lce_cmd_state_i  = lce_pkg::e_coh_i;
    lce_cmd_data_i   = '0;
    tag_mem_yumi_i   = 1'b1;
    data_mem_yumi_i  = 1'b1;
    lce_resp_ready_i = 1'b1;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    check_eq("lce_req_v_o", 64'(lce_req_v_o), 64'(0));
    check_eq("lce_resp_v_o", 64'(lce_resp_v_o), 64'(0));
    check_eq("tag_mem_v_o", 64'(tag_mem_v_o), 64'(0));
    check_eq("data_mem_v_o", 64'(data_mem_v_o), 64'(0));
    check_eq("lce_cmd_yumi_o", 64'(lce_cmd_yumi_o), 64'(0));
    check_eq("cache_req_complete_o", 64'(cache_req_complete_o), 64'(0));
    check_eq("credits_empty_o", 64'(credits_empty_o), 64'(1));

    // One miss held by the directory, then its fill
    lce_req_ready_i = 1'b0;
    send_miss(lce_pkg::e_req_wr, 16'h1a28);
    repeat (3) step();
    lce_req_ready_i = 1'b1;
    serve_fills(1);
    wait_quiet();
    check_eq("credits_empty_o", 64'(credits_empty_o), 64'(1));

    // Invalidate touches only the tag
    send_cmd(lce_pkg::e_cmd_inval, 16'hc3f0, 1'b1, lce_pkg::e_coh_m, 64'h0123_4567_89ab_cdef);
    wait_quiet();

    // Four misses use up the credits
    for (int i = 0; i < 4; i++) begin
      send_miss(lce_pkg::e_req_rd, 16'h0400 + 16'(i * 8));
    end
    n = 0;
    while (!credits_full_o) begin
      n++;
      if (n > wait_limit_lp) timeout_fail("credits_full_o");
      step();
    end
    check_eq("cache_req_ready_o", 64'(cache_req_ready_o), 64'(0));
    serve_fills(4);
    wait_quiet();
    check_eq("credits_empty_o", 64'(credits_empty_o), 64'(1));

    // Blocked tag port, ready drops from the fifth blocked cycle
    tag_mem_yumi_i = 1'b0;
    send_cmd(lce_pkg::e_cmd_inval, 16'h7788, 1'b0, lce_pkg::e_coh_s, 64'h0);
    for (int i = 0; i < 8; i++) begin
      check_eq("tag_mem_v_o", 64'(tag_mem_v_o), 64'(1));
      // Loop pass i sits in blocked cycle i+1
      check_eq("cache_req_ready_o", 64'(cache_req_ready_o), 64'(i + 1 < 5));
      step();
    end
    tag_mem_yumi_i = 1'b1;
    n = 0;
    while (!cache_req_ready_o) begin
      n++;
      if (n > wait_limit_lp) timeout_fail("cache_req_ready_o to return");
      step();
    end
    wait_quiet();

    // Random mix of misses, fills and invalidates
    rand_bp = 1'b1;
    for (int round = 0; round < 12; round++) begin
      r = rnd();
      k = (r[1:0] == 2'd0) ? 1 : int'(r[1:0]);
      for (int i = 0; i < k; i++) begin
        r = rnd();
        send_miss(r[16] ? lce_pkg::e_req_wr : lce_pkg::e_req_rd, r[15:0]);
      end
      r = rnd();
      send_cmd(lce_pkg::e_cmd_inval, r[15:0], r[16], lce_pkg::e_coh_s, {rnd(), rnd()});
      serve_fills(k);
    end
    wait_quiet();
    rand_bp = 1'b0;
    check_eq("credits_empty_o", 64'(credits_empty_o), 64'(1));

    $display("RESULT: PASS");
    $finish;
  end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build the LCE testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_lce -f src.f -o tb_lce_sim
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

sim_out=$(./obj_dir/tb_lce_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "RESULT: PASS"; then
  exit 0
fi
echo "Pass line not found in simulation output"
exit 1

// ==== src.f ====
design/lce_pkg.sv
design/lce_req.sv
design/lce_cmd.sv
design/lce_stall_timer.sv
design/lce_top.sv
dv/lce_asserts.sv
dv/tb_lce.sv
